// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_gpu_frontend
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/frontend_model.svh
// ****************************************
// Reference model, included inside the testbench module
// Expects gpu_fe_pkg to be imported by the includer
// ****************************************

`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

typedef struct packed {
  addr_t        pc;
  warp_id_t     warp;
  thread_mask_t mask;
  opcode_t      opcode;
  reg_idx_t     rd;
  reg_idx_t     rs1;
  reg_idx_t     rs2;
  data_t        imm;
} entry_t;

thread_mask_t model_mask  [NUM_WARPS];
addr_t        model_pc    [NUM_WARPS];
logic         model_stall [NUM_WARPS];
entry_t       exp_q [$];  // Buffer contents, head first

function automatic logic opcode_known(opcode_t op);
  return op inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                    OPC_LOAD, OPC_STORE, OPC_ARITHI, OPC_ARITH};
endfunction

// Expected register fields and immediate, per RV32I formats
function automatic entry_t expect_fields(inst_word_t inst);
  entry_t e;
  int     sx;  // Arithmetic shift spreads the sign bit
  e        = '0;
  e.opcode = inst[6:0];
  if (!opcode_known(e.opcode)) return e;
  if (!(e.opcode inside {OPC_BRANCH, OPC_STORE})) e.rd = inst[11:7];
  if (!(e.opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL})) e.rs1 = inst[19:15];
  if (e.opcode inside {OPC_BRANCH, OPC_STORE, OPC_ARITH}) e.rs2 = inst[24:20];
  case (e.opcode)
    OPC_LUI, OPC_AUIPC: e.imm = inst & 32'hffff_f000;
    OPC_JALR, OPC_LOAD, OPC_ARITHI: begin
      sx    = int'(inst) >>> 20;
      e.imm = sx;
    end
    OPC_STORE: begin
      sx    = int'(inst) >>> 20;
      e.imm = (sx & ~32'h1f) | 32'(inst[11:7]);
    end
    OPC_BRANCH: begin
      sx    = int'(inst) >>> 19;
      e.imm = (sx & 32'hffff_f000) | 32'({inst[7], inst[30:25], inst[11:8], 1'b0});
    end
    OPC_JAL: begin
      sx    = int'(inst) >>> 11;
      e.imm = (sx & 32'hfff0_0000) | 32'({inst[19:12], inst[20], inst[30:21], 1'b0});
    end
    default: e.imm = '0;  // R-type
  endcase
  return e;
endfunction

// Split-table effect of one decoded instruction
function automatic void apply_next_pc(entry_t e);
  if (e.opcode inside {OPC_AUIPC, OPC_BRANCH}) model_stall[e.warp] = 1'b1;
  else if (e.opcode inside {OPC_JAL, OPC_JALR}) model_pc[e.warp] = e.pc + e.imm;
  else model_pc[e.warp] = e.pc + 32'd4;
endfunction

function automatic void reset_model();
  for (int w = 0; w < NUM_WARPS; w++) begin
    model_mask[w]  = '1;
    model_pc[w]    = '0;
    model_stall[w] = 1'b0;
  end
  exp_q.delete();
endfunction

`endif

// File: dv/tb_gpu_frontend.sv
// ****************************************
// Random traffic on the warp front end, fixed seed
// Model tracks advance cycles, buffer count and table
// Mask loads only while no instruction is presented
// ****************************************

`timescale 1ns/1ns

module tb_gpu_frontend
  import gpu_fe_pkg::*;
();

  `include "frontend_model.svh"

  logic         clk;
  logic         rst_n;
  logic         rdy;
  logic         fetch_valid;
  inst_word_t   fetch_inst;
  addr_t        fetch_pc;
  warp_id_t     fetch_warp;
  logic         mask_load;
  warp_id_t     mask_warp;
  thread_mask_t mask_value;
  warp_id_t     query_warp;
  addr_t        query_pc;
  logic         query_stalled;
  logic         issue_pop;
  logic         issue_valid;
  addr_t        issue_pc;
  warp_id_t     issue_warp;
  thread_mask_t issue_mask;
  opcode_t      issue_opcode;
  reg_idx_t     issue_rd;
  reg_idx_t     issue_rs1;
  reg_idx_t     issue_rs2;
  data_t        issue_imm;
  logic         decode_error;

  int       errors;
  int       popped;
  int       issued;        // Pops the DUT accepted with issue_valid high
  int       legal_sent;
  int       mcount;        // Entries the buffer should hold
  logic     push_pending;  // DUT writes the buffer at the next edge
  entry_t   pend_entry;
  entry_t   cur_entry;
  logic     cur_legal;
  logic     in_flight;
  int       adv_seen;      // Advance cycles seen by the current instruction
  logic     exp_error;
  int       to_send;
  int       illegal_pct;
  logic     pop_hold;
  logic     rdy_random;
  logic     loads_on;
  logic     timed_out;
  warp_id_t query_sel;

  gpu_frontend_top u_gpu_frontend_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .rdy           (rdy),
    .fetch_valid   (fetch_valid),
    .fetch_inst    (fetch_inst),
    .fetch_pc      (fetch_pc),
    .fetch_warp    (fetch_warp),
    .mask_load     (mask_load),
    .mask_warp     (mask_warp),
    .mask_value    (mask_value),
    .query_warp    (query_warp),
    .query_pc      (query_pc),
    .query_stalled (query_stalled),
    .issue_pop     (issue_pop),
    .issue_valid   (issue_valid),
    .issue_pc      (issue_pc),
    .issue_warp    (issue_warp),
    .issue_mask    (issue_mask),
    .issue_opcode  (issue_opcode),
    .issue_rd      (issue_rd),
    .issue_rs1     (issue_rs1),
    .issue_rs2     (issue_rs2),
    .issue_imm     (issue_imm),
    .decode_error  (decode_error)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_field(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // Model state moves on the edge, using inputs driven a cycle earlier
  task automatic model_edge();
    logic adv;
    logic take;
    adv  = rdy && (mcount < IBUF_DEPTH);
    take = issue_pop && (mcount > 0);
    if (take) begin
      void'(exp_q.pop_front());
      popped++;
    end
    if (push_pending) exp_q.push_back(pend_entry);
    mcount       = mcount + int'(push_pending) - int'(take);
    push_pending = 1'b0;
    if (in_flight && fetch_valid && adv) begin
      adv_seen++;
      if (adv_seen == 2) begin  // Second advance is the UPDATE step
        in_flight = 1'b0;
        if (cur_legal) begin
          cur_entry.mask = model_mask[cur_entry.warp];
          pend_entry     = cur_entry;
          push_pending   = 1'b1;
          legal_sent++;
          apply_next_pc(cur_entry);
        end else begin
          exp_error = 1'b1;
        end
      end
    end
    if (mask_load) model_mask[mask_warp] = mask_value;
  endtask

  task automatic new_instruction();
    inst_word_t inst;
    opcode_t    op;
    warp_id_t   w;
    opcode_t    classes [9];
    classes = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                OPC_LOAD, OPC_STORE, OPC_ARITHI, OPC_ARITH};
    w = warp_id_t'($urandom_range(NUM_WARPS - 1));
    if ($urandom_range(99) < illegal_pct) begin
      do op = opcode_t'($urandom); while (opcode_known(op));
    end else begin
      op = classes[$urandom_range(8)];
    end
    inst           = $urandom;
    inst[6:0]      = op;
    cur_entry      = expect_fields(inst);
    cur_entry.pc   = model_pc[w];
    cur_entry.warp = w;
    cur_legal      = opcode_known(op);
    fetch_valid    = 1'b1;
    fetch_inst     = inst;
    fetch_pc       = model_pc[w];
    fetch_warp     = w;
    in_flight      = 1'b1;
    adv_seen       = 0;
    to_send--;
  endtask

  task automatic drive_inputs();
    rdy        = rdy_random ? ($urandom_range(3) != 0) : 1'b1;
    issue_pop  = pop_hold ? 1'b0 : ($urandom_range(1) == 1);
    mask_load  = 1'b0;
    query_warp = query_sel;
    if (!in_flight && to_send > 0 && $urandom_range(3) != 0) begin
      new_instruction();
    end else if (!in_flight) begin
      fetch_valid = 1'b0;
      if (loads_on && $urandom_range(3) == 0) begin
        mask_load  = 1'b1;
        mask_warp  = warp_id_t'($urandom_range(NUM_WARPS - 1));
        mask_value = thread_mask_t'($urandom);
      end
    end
  endtask

  task automatic check_outputs();
    entry_t h;
    if (issue_valid !== (mcount != 0)) begin
      errors++;
      $display("Error at %0t ns: issue_valid expected %0b got %0b",
               $time, mcount != 0, issue_valid);
    end
    if (decode_error !== exp_error) begin
      errors++;
      $display("Error at %0t ns: decode_error expected %0b got %0b",
               $time, exp_error, decode_error);
    end
    if (issue_pop && issue_valid) issued++;
    if (issue_pop && mcount != 0) begin  // Head leaves at the next edge
      h = exp_q[0];
      check_field("issue_pc", h.pc, issue_pc);
      check_field("issue_warp", 32'(h.warp), 32'(issue_warp));
      check_field("issue_mask", 32'(h.mask), 32'(issue_mask));
      check_field("issue_opcode", 32'(h.opcode), 32'(issue_opcode));
      check_field("issue_rd", 32'(h.rd), 32'(issue_rd));
      check_field("issue_rs1", 32'(h.rs1), 32'(issue_rs1));
      check_field("issue_rs2", 32'(h.rs2), 32'(issue_rs2));
      check_field("issue_imm", h.imm, issue_imm);
    end
  endtask

  task automatic run_cycle();
    @(posedge clk);
    model_edge();
    #1;
    drive_inputs();
    @(negedge clk);
    check_outputs();
  endtask

  function automatic logic busy();
    return to_send > 0 || in_flight || push_pending || mcount != 0;
  endfunction

  task automatic wait_idle(int limit, string what);
    int n;
    n = 0;
    while (busy() && n < limit) begin
      run_cycle();
      n++;
    end
    if (busy()) begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout after %0d cycles waiting for %s", limit, what);
    end
  endtask

  task automatic wait_full(int limit);
    int n;
    n = 0;
    while (mcount < IBUF_DEPTH && n < limit) begin
      run_cycle();
      n++;
    end
    if (mcount < IBUF_DEPTH) begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout after %0d cycles waiting for the buffer to fill", limit);
    end
  endtask

  initial begin
    errors       = 0;
    popped       = 0;
    issued       = 0;
    legal_sent   = 0;
    mcount       = 0;
    push_pending = 1'b0;
    in_flight    = 1'b0;
    adv_seen     = 0;
    exp_error    = 1'b0;
    to_send      = 0;
    illegal_pct  = 0;
    pop_hold     = 1'b0;
    rdy_random   = 1'b1;
    loads_on     = 1'b1;
    timed_out    = 1'b0;
    query_sel    = '0;
    rst_n        = 1'b0;
    rdy          = 1'b0;
    fetch_valid  = 1'b0;
    fetch_inst   = '0;
    fetch_pc     = '0;
    fetch_warp   = '0;
    mask_load    = 1'b0;
    mask_warp    = '0;
    mask_value   = '0;
    query_warp   = '0;
    issue_pop    = 1'b0;
    void'($urandom(66499));
    reset_model();
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;

    // Mixed traffic with random rdy, pops and mask loads
    to_send = 200;
    wait_idle(4000, "random traffic to drain");

    // Pops held low until the buffer fills, then decode sits frozen
    if (!timed_out) begin
      rdy_random = 1'b0;
      pop_hold   = 1'b1;
      to_send    = IBUF_DEPTH + 4;
      wait_full(200);
    end
    if (!timed_out) begin
      repeat (2 * IBUF_DEPTH) run_cycle();
      pop_hold   = 1'b0;
      rdy_random = 1'b1;
      wait_idle(2000, "buffer to drain after back-pressure");
    end

    // Some undefined opcodes mixed in
    if (!timed_out) begin
      illegal_pct = 30;
      to_send     = 40;
      wait_idle(2000, "traffic with illegal opcodes to drain");
      if (!exp_error) begin
        errors++;
        $display("No illegal opcode reached decode");
      end
    end

    // Final PC and stall of every warp
    if (!timed_out) begin
      loads_on = 1'b0;
      for (int w = 0; w < NUM_WARPS; w++) begin
        query_sel = warp_id_t'(w);
        run_cycle();
        check_field("query_pc", model_pc[w], query_pc);
        check_field("query_stalled", 32'(model_stall[w]), 32'(query_stalled));
      end
      if (issued != legal_sent) begin
        errors++;
        $display("Issued %0d entries but %0d were written", issued, legal_sent);
      end
    end

    $display("Errors: %0d, entries checked: %0d", errors, popped);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+dv
source/gpu_fe_pkg.sv
source/idecode_fields.sv
source/split_table.sv
source/inst_buffer.sv
source/warp_decode.sv
source/gpu_frontend_top.sv
dv/tb_gpu_frontend.sv

// File: source/gpu_fe_pkg.sv
// ****************************************
// Shared widths, opcodes and types of the warp front end
// Opcode sits in bits 6..0 as in RV32I
// IBUF_DEPTH must be a power of two
// ****************************************

package gpu_fe_pkg;

  localparam int NUM_WARPS   = 4;
  localparam int NUM_THREADS = 8;
  localparam int IBUF_DEPTH  = 4;

  localparam int WARP_W     = $clog2(NUM_WARPS);
  localparam int IBUF_PTR_W = $clog2(IBUF_DEPTH);
  localparam int IBUF_CNT_W = $clog2(IBUF_DEPTH + 1);

  typedef logic [31:0]          inst_word_t;
  typedef logic [31:0]          addr_t;
  typedef logic [31:0]          data_t;
  typedef logic [WARP_W-1:0]    warp_id_t;
  typedef logic [NUM_THREADS-1:0] thread_mask_t;
  typedef logic [4:0]           reg_idx_t;
  typedef logic [6:0]           opcode_t;
  typedef logic [IBUF_PTR_W-1:0] ibuf_ptr_t;
  typedef logic [IBUF_CNT_W-1:0] ibuf_cnt_t;

  // Major opcodes, standard RV32I encoding
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_ARITHI = 7'b0010011;
  localparam opcode_t OPC_ARITH  = 7'b0110011;

  // Decode sequencer states
  typedef enum logic {
    IDLE,
    UPDATE
  } decode_state_t;

endpackage

// File: source/gpu_frontend_top.sv
// ****************************************
// Warp front end: decode, split table, buffer
// No handshake on fetch; rdy is a level enable
// ****************************************

`timescale 1ns/1ns

module gpu_frontend_top
  import gpu_fe_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         rdy,
  input  logic         fetch_valid,
  input  inst_word_t   fetch_inst,
  input  addr_t        fetch_pc,
  input  warp_id_t     fetch_warp,
  input  logic         mask_load,
  input  warp_id_t     mask_warp,
  input  thread_mask_t mask_value,
  input  warp_id_t     query_warp,
  output addr_t        query_pc,
  output logic         query_stalled,
  input  logic         issue_pop,
  output logic         issue_valid,
  output addr_t        issue_pc,
  output warp_id_t     issue_warp,
  output thread_mask_t issue_mask,
  output opcode_t      issue_opcode,
  output reg_idx_t     issue_rd,
  output reg_idx_t     issue_rs1,
  output reg_idx_t     issue_rs2,
  output data_t        issue_imm,
  output logic         decode_error
);

  warp_id_t     rd_warp;
  thread_mask_t rd_mask;
  logic         upd_valid;
  warp_id_t     upd_warp;
  addr_t        upd_pc;
  logic         upd_stall;
  logic         wr_valid;
  addr_t        wr_pc;
  warp_id_t     wr_warp;
  thread_mask_t wr_mask;
  opcode_t      wr_opcode;
  reg_idx_t     wr_rd;
  reg_idx_t     wr_rs1;
  reg_idx_t     wr_rs2;
  data_t        wr_imm;
  logic         buf_full;
  logic         buf_empty;

  assign issue_valid = !buf_empty;

  warp_decode u_warp_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .rdy          (rdy),
    .buf_full     (buf_full),
    .fetch_valid  (fetch_valid),
    .fetch_inst   (fetch_inst),
    .fetch_pc     (fetch_pc),
    .fetch_warp   (fetch_warp),
    .rd_warp      (rd_warp),
    .rd_mask      (rd_mask),
    .upd_valid    (upd_valid),
    .upd_warp     (upd_warp),
    .upd_pc       (upd_pc),
    .upd_stall    (upd_stall),
    .wr_valid     (wr_valid),
    .wr_pc        (wr_pc),
    .wr_warp      (wr_warp),
    .wr_mask      (wr_mask),
    .wr_opcode    (wr_opcode),
    .wr_rd        (wr_rd),
    .wr_rs1       (wr_rs1),
    .wr_rs2       (wr_rs2),
    .wr_imm       (wr_imm),
    .decode_error (decode_error)
  );

  split_table u_split_table (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_warp       (rd_warp),
    .rd_mask       (rd_mask),
    .upd_valid     (upd_valid),
    .upd_warp      (upd_warp),
    .upd_pc        (upd_pc),
    .upd_stall     (upd_stall),
    .mask_load     (mask_load),
    .mask_warp     (mask_warp),
    .mask_value    (mask_value),
    .query_warp    (query_warp),
    .query_pc      (query_pc),
    .query_stalled (query_stalled)
  );

  inst_buffer u_inst_buffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_valid    (wr_valid),
    .wr_pc       (wr_pc),
    .wr_warp     (wr_warp),
    .wr_mask     (wr_mask),
    .wr_opcode   (wr_opcode),
    .wr_rd       (wr_rd),
    .wr_rs1      (wr_rs1),
    .wr_rs2      (wr_rs2),
    .wr_imm      (wr_imm),
    .pop         (issue_pop),
    .full        (buf_full),
    .empty       (buf_empty),
    .head_pc     (issue_pc),
    .head_warp   (issue_warp),
    .head_mask   (issue_mask),
    .head_opcode (issue_opcode),
    .head_rd     (issue_rd),
    .head_rs1    (issue_rs1),
    .head_rs2    (issue_rs2),
    .head_imm    (issue_imm)
  );

endmodule

// File: source/idecode_fields.sv
// ****************************************
// Pure combinational field extraction
// Fields a format does not use are driven to zero
// ****************************************

`timescale 1ns/1ns

module idecode_fields
  import gpu_fe_pkg::*;
(
  input  inst_word_t inst,
  output opcode_t    opcode,
  output reg_idx_t   rd,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output data_t      imm,
  output logic       illegal
);

  assign opcode = inst[6:0];

  always_comb begin
    rd      = '0;
    rs1     = '0;
    rs2     = '0;
    imm     = '0;
    illegal = 1'b0;
    case (opcode)
      OPC_LUI, OPC_AUIPC: begin  // U-type
        rd  = inst[11:7];
        imm = {inst[31:12], 12'b0};
      end
      OPC_JAL: begin  // J-type
        rd  = inst[11:7];
        imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      OPC_JALR, OPC_LOAD, OPC_ARITHI: begin  // I-type
        rd  = inst[11:7];
        rs1 = inst[19:15];
        imm = {{20{inst[31]}}, inst[31:20]};
      end
      OPC_BRANCH: begin  // B-type
        rs1 = inst[19:15];
        rs2 = inst[24:20];
        imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      OPC_STORE: begin  // S-type
        rs1 = inst[19:15];
        rs2 = inst[24:20];
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      OPC_ARITH: begin
        // R-type carries no immediate
        rd  = inst[11:7];
        rs1 = inst[19:15];
        rs2 = inst[24:20];
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

endmodule

// File: source/inst_buffer.sv
// ****************************************
// Circular FIFO of decoded instructions
// A write while full lands only with a pop
// Pops while empty are ignored
// ****************************************

`timescale 1ns/1ns

module inst_buffer
  import gpu_fe_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         wr_valid,
  input  addr_t        wr_pc,
  input  warp_id_t     wr_warp,
  input  thread_mask_t wr_mask,
  input  opcode_t      wr_opcode,
  input  reg_idx_t     wr_rd,
  input  reg_idx_t     wr_rs1,
  input  reg_idx_t     wr_rs2,
  input  data_t        wr_imm,
  input  logic         pop,
  output logic         full,
  output logic         empty,
  output addr_t        head_pc,
  output warp_id_t     head_warp,
  output thread_mask_t head_mask,
  output opcode_t      head_opcode,
  output reg_idx_t     head_rd,
  output reg_idx_t     head_rs1,
  output reg_idx_t     head_rs2,
  output data_t        head_imm
);

  addr_t        pc_mem     [IBUF_DEPTH];
  warp_id_t     warp_mem   [IBUF_DEPTH];
  thread_mask_t mask_mem   [IBUF_DEPTH];
  opcode_t      opcode_mem [IBUF_DEPTH];
  reg_idx_t     rd_mem     [IBUF_DEPTH];
  reg_idx_t     rs1_mem    [IBUF_DEPTH];
  reg_idx_t     rs2_mem    [IBUF_DEPTH];
  data_t        imm_mem    [IBUF_DEPTH];

  ibuf_ptr_t wr_ptr;
  ibuf_ptr_t rd_ptr;
  ibuf_cnt_t count;
  logic      push;
  logic      take;

  assign full  = (count == ibuf_cnt_t'(IBUF_DEPTH));
  assign empty = (count == '0);
  assign push  = wr_valid && (!full || take);  // Head slot frees at the same edge
  assign take  = pop && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power-of-two depth
      if (take) rd_ptr <= rd_ptr + 1'b1;
      if (push && !take) count <= count + 1'b1;
      else if (take && !push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      pc_mem[wr_ptr]     <= wr_pc;
      warp_mem[wr_ptr]   <= wr_warp;
      mask_mem[wr_ptr]   <= wr_mask;
      opcode_mem[wr_ptr] <= wr_opcode;
      rd_mem[wr_ptr]     <= wr_rd;
      rs1_mem[wr_ptr]    <= wr_rs1;
      rs2_mem[wr_ptr]    <= wr_rs2;
      imm_mem[wr_ptr]    <= wr_imm;
    end
  end

  // Head entry, meaningful only while not empty
  assign head_pc     = pc_mem[rd_ptr];
  assign head_warp   = warp_mem[rd_ptr];
  assign head_mask   = mask_mem[rd_ptr];
  assign head_opcode = opcode_mem[rd_ptr];
  assign head_rd     = rd_mem[rd_ptr];
  assign head_rs1    = rs1_mem[rd_ptr];
  assign head_rs2    = rs2_mem[rd_ptr];
  assign head_imm    = imm_mem[rd_ptr];

endmodule

// File: source/split_table.sv
// ****************************************
// Per-warp mask, PC and stall flag
// Stall is sticky until reset; a stalling update keeps the PC
// ****************************************

`timescale 1ns/1ns

module split_table
  import gpu_fe_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  warp_id_t     rd_warp,
  output thread_mask_t rd_mask,
  input  logic         upd_valid,
  input  warp_id_t     upd_warp,
  input  addr_t        upd_pc,
  input  logic         upd_stall,
  input  logic         mask_load,
  input  warp_id_t     mask_warp,
  input  thread_mask_t mask_value,
  input  warp_id_t     query_warp,
  output addr_t        query_pc,
  output logic         query_stalled
);

  thread_mask_t mask_q  [NUM_WARPS];
  addr_t        pc_q    [NUM_WARPS];
  logic         stall_q [NUM_WARPS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < NUM_WARPS; w++) begin
        mask_q[w]  <= '1;  // All lanes active
        pc_q[w]    <= '0;
        stall_q[w] <= 1'b0;
      end
    end else begin
      // Updates never touch the mask
      if (mask_load) mask_q[mask_warp] <= mask_value;
      if (upd_valid) begin
        if (upd_stall) stall_q[upd_warp] <= 1'b1;
        else pc_q[upd_warp] <= upd_pc;
      end
    end
  end

  assign rd_mask       = mask_q[rd_warp];
  assign query_pc      = pc_q[query_warp];
  assign query_stalled = stall_q[query_warp];

endmodule

// File: source/warp_decode.sv
// ****************************************
// Two-state decode sequencer, moves only on advance cycles
// Fetch inputs must hold for two advance cycles
// Illegal opcodes only set the sticky decode_error
// ****************************************

`timescale 1ns/1ns

module warp_decode
  import gpu_fe_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         rdy,
  input  logic         buf_full,
  input  logic         fetch_valid,
  input  inst_word_t   fetch_inst,
  input  addr_t        fetch_pc,
  input  warp_id_t     fetch_warp,
  output warp_id_t     rd_warp,
  input  thread_mask_t rd_mask,
  output logic         upd_valid,
  output warp_id_t     upd_warp,
  output addr_t        upd_pc,
  output logic         upd_stall,
  output logic         wr_valid,
  output addr_t        wr_pc,
  output warp_id_t     wr_warp,
  output thread_mask_t wr_mask,
  output opcode_t      wr_opcode,
  output reg_idx_t     wr_rd,
  output reg_idx_t     wr_rs1,
  output reg_idx_t     wr_rs2,
  output data_t        wr_imm,
  output logic         decode_error
);

  decode_state_t state;
  warp_id_t      cur_warp;  // Warp latched in IDLE
  opcode_t       dec_opcode;
  reg_idx_t      dec_rd;
  reg_idx_t      dec_rs1;
  reg_idx_t      dec_rs2;
  data_t         dec_imm;
  logic          dec_illegal;
  logic          advance;
  logic          do_update;

  idecode_fields u_idecode_fields (
    .inst    (fetch_inst),
    .opcode  (dec_opcode),
    .rd      (dec_rd),
    .rs1     (dec_rs1),
    .rs2     (dec_rs2),
    .imm     (dec_imm),
    .illegal (dec_illegal)
  );

  // A full buffer stalls exactly like rdy low
  assign advance   = rdy && !buf_full;
  assign do_update = advance && (state == UPDATE) && !dec_illegal;
  assign rd_warp   = cur_warp;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= IDLE;
      cur_warp     <= '0;
      wr_valid     <= 1'b0;
      upd_valid    <= 1'b0;
      decode_error <= 1'b0;
    end else begin
      wr_valid  <= do_update;  // Single-cycle strobes
      upd_valid <= do_update;
      if (advance) begin
        case (state)
          IDLE: begin
            if (fetch_valid) begin
              cur_warp <= fetch_warp;
              state    <= UPDATE;
            end
          end
          UPDATE: begin
            if (dec_illegal) decode_error <= 1'b1;
            state <= IDLE;
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // Buffer entry and table update payload
  always_ff @(posedge clk) begin
    if (do_update) begin
      wr_pc     <= fetch_pc;
      wr_warp   <= cur_warp;
      wr_mask   <= rd_mask;
      wr_opcode <= dec_opcode;
      wr_rd     <= dec_rd;
      wr_rs1    <= dec_rs1;
      wr_rs2    <= dec_rs2;
      wr_imm    <= dec_imm;
      upd_warp  <= cur_warp;
      if (dec_opcode == OPC_AUIPC || dec_opcode == OPC_BRANCH) begin
        upd_stall <= 1'b1;
        upd_pc    <= fetch_pc;  // Table keeps its PC on a stall
      end else if (dec_opcode == OPC_JAL || dec_opcode == OPC_JALR) begin
        upd_stall <= 1'b0;
        upd_pc    <= fetch_pc + dec_imm;  // rs1 not read for JALR
      end else begin
        upd_stall <= 1'b0;
        upd_pc    <= fetch_pc + 32'd4;
      end
    end
  end

endmodule
